// ==== logic/uart_pkg.sv ====
// serial line format for the BLE receive chain
// 8 data bits, no parity, one stop bit, 16x oversampling only
// DIV_W bounds the divisor of the tick generator

package uart_pkg;

   // ***************************************
   // line format
   // ***************************************

   // data bits per character, LSB first on the line
   parameter int DATA_BITS = 8;

   // oversampling ticks per bit
   parameter int OVERSAMPLE = 16;

   // divisor counter width, enough for 100 MHz down to 9600 baud
   parameter int DIV_W = 11;

   // ***************************************
   // receiver output
   // ***************************************

   // one received character
   // valid is a single-cycle strobe, data only meaningful with it
   typedef struct packed {
      logic                 valid;
      logic [DATA_BITS-1:0] data;
   } uart_byte_t;

endpackage

// ==== logic/accel_pkg.sv ====
// accelerometer frame as sent over the BLE link
// eight ASCII hex characters, first one most significant, ended by CR
// no separators or sign characters are understood

package accel_pkg;

   // ***************************************
   // frame format
   // ***************************************

   // hex characters per frame
   parameter int FRAME_CHARS = 8;

   // end of frame
   parameter logic [7:0] ASCII_CR = 8'h0D;

   // hex digit ranges
   parameter logic [7:0] ASCII_0    = 8'h30;
   parameter logic [7:0] ASCII_9    = 8'h39;
   parameter logic [7:0] ASCII_A_UP = 8'h41;
   parameter logic [7:0] ASCII_F_UP = 8'h46;
   parameter logic [7:0] ASCII_A_LO = 8'h61;
   parameter logic [7:0] ASCII_F_LO = 8'h66;

   // ***************************************
   // types
   // ***************************************

   typedef logic [7:0] ascii_char_t;

   // chars[FRAME_CHARS-1] holds the first character received
   typedef struct packed {
      logic                              valid;
      logic                              len_ok;
      ascii_char_t [FRAME_CHARS-1:0]     chars;
   } hex_frame_t;

   // decoded value, four bits per character
   typedef logic [31:0] accel_val_t;

endpackage

// ==== logic/baud_tick_gen.sv ====
// free running 16x oversampling tick
// CLKS_PER_TICK must be at least 1 and fit in DIV_W bits
// 100 MHz at 115200 baud gives 54

`timescale 1ns/1ps

module baud_tick_gen #(
   parameter logic [uart_pkg::DIV_W-1:0] CLKS_PER_TICK = 11'd54
) (
   input  logic clk,
   input  logic i_rst_n,
   output logic o_tick
);

   import uart_pkg::*;

   // down counter, tick on the reload
   logic [DIV_W-1:0] div_cnt;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         div_cnt <= CLKS_PER_TICK - DIV_W'(1);
         o_tick  <= 1'b0;
      end else if (div_cnt == '0) begin
         // one pulse per CLKS_PER_TICK clocks
         div_cnt <= CLKS_PER_TICK - DIV_W'(1);
         o_tick  <= 1'b1;
      end else begin
         div_cnt <= div_cnt - DIV_W'(1);
         o_tick  <= 1'b0;
      end
   end

endmodule

// ==== logic/uart_byte_rx.sv ====
// 8N1 receiver, 16x oversampled, samples each bit at its middle
// a low stop bit drops the byte silently, no error is reported
// i_rx may be asynchronous, it is synchronized here

`timescale 1ns/1ps

module uart_byte_rx (
   input  logic                clk,
   input  logic                i_rst_n,
   input  logic                i_tick,
   input  logic                i_rx,
   output uart_pkg::uart_byte_t o_byte
);

   import uart_pkg::*;

   localparam int TICK_W = $clog2(OVERSAMPLE);
   localparam int BIT_W  = $clog2(DATA_BITS);

   typedef enum logic [2:0] {
      st_idle,
      st_start,
      st_data,
      st_stop,
      st_wait_high
   } rx_state_t;

   rx_state_t            state;
   logic                 rx_meta;
   logic                 rx_sync;
   logic [TICK_W-1:0]    tick_cnt;
   logic [BIT_W-1:0]     bit_cnt;
   logic [DATA_BITS-1:0] shreg;
   logic                 byte_vld;

   // ***************************************
   // input synchronizer
   // ***************************************

   // idle line is high
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= i_rx;
         rx_sync <= rx_meta;
      end
   end

   // ***************************************
   // bit timing FSM
   // ***************************************

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state    <= st_idle;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         byte_vld <= 1'b0;
      end else begin
         byte_vld <= 1'b0;
         case (state)
            st_idle: begin
               // falling edge starts the count
               if (!rx_sync) begin
                  state    <= st_start;
                  tick_cnt <= '0;
               end
            end
            st_start: begin
               if (i_tick) begin
                  // half a bit in, start must still be low
                  if (tick_cnt == TICK_W'(OVERSAMPLE / 2 - 1)) begin
                     tick_cnt <= '0;
                     bit_cnt  <= '0;
                     state    <= rx_sync ? st_idle : st_data;
                  end else begin
                     tick_cnt <= tick_cnt + TICK_W'(1);
                  end
               end
            end
            st_data: begin
               if (i_tick) begin
                  if (tick_cnt == TICK_W'(OVERSAMPLE - 1)) begin
                     tick_cnt <= '0;
                     if (bit_cnt == BIT_W'(DATA_BITS - 1)) begin
                        state <= st_stop;
                     end else begin
                        bit_cnt <= bit_cnt + BIT_W'(1);
                     end
                  end else begin
                     tick_cnt <= tick_cnt + TICK_W'(1);
                  end
               end
            end
            st_stop: begin
               if (i_tick) begin
                  if (tick_cnt == TICK_W'(OVERSAMPLE - 1)) begin
                     tick_cnt <= '0;
                     // good stop bit, line is already high again
                     byte_vld <= rx_sync;
                     state    <= rx_sync ? st_idle : st_wait_high;
                  end else begin
                     tick_cnt <= tick_cnt + TICK_W'(1);
                  end
               end
            end
            st_wait_high: begin
               // bad stop or break, hold off until the line recovers
               if (rx_sync) begin
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // data shift register, LSB arrives first
   always_ff @(posedge clk) begin
      if (state == st_data && i_tick && tick_cnt == TICK_W'(OVERSAMPLE - 1)) begin
         shreg <= {rx_sync, shreg[DATA_BITS-1:1]};
      end
   end

   // shreg is stable once the stop bit is reached
   assign o_byte = '{valid: byte_vld, data: shreg};

endmodule

// ==== logic/hex_frame_collect.sv ====
// gathers characters into an eight character window up to a CR
// only the last eight characters before the CR are kept
// length check uses a count that saturates at FRAME_CHARS + 1

`timescale 1ns/1ps

module hex_frame_collect (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  uart_pkg::uart_byte_t   i_byte,
   output accel_pkg::hex_frame_t  o_frame
);

   import accel_pkg::*;

   localparam int CNT_W = $clog2(FRAME_CHARS + 2);

   ascii_char_t [FRAME_CHARS-1:0] char_buf;
   logic [CNT_W-1:0]              char_cnt;
   logic                          frame_vld;
   logic                          len_ok;
   logic                          is_cr;

   assign is_cr = (i_byte.data == ASCII_CR);

   // ***************************************
   // character window
   // ***************************************

   // oldest character shifts toward the top
   always_ff @(posedge clk) begin
      if (i_byte.valid && !is_cr) begin
         char_buf <= {char_buf[FRAME_CHARS-2:0], i_byte.data};
      end
   end

   // one past a full frame is enough to flag too long
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         char_cnt  <= '0;
         frame_vld <= 1'b0;
      end else begin
         frame_vld <= i_byte.valid && is_cr;
         if (i_byte.valid) begin
            if (is_cr) begin
               char_cnt <= '0;
            end else if (char_cnt != CNT_W'(FRAME_CHARS + 1)) begin
               char_cnt <= char_cnt + CNT_W'(1);
            end
         end
      end
   end

   // a bare CR still yields a frame, flagged short
   always_ff @(posedge clk) begin
      if (i_byte.valid && is_cr) begin
         len_ok <= (char_cnt == CNT_W'(FRAME_CHARS));
      end
   end

   // window holds until the next character, well after the strobe
   assign o_frame = '{valid: frame_vld, len_ok: len_ok, chars: char_buf};

endmodule

// ==== logic/hex_word_decode.sv ====
// ASCII hex to binary, upper and lower case digits accepted
// o_value only changes on a fully good frame
// every other frame gives a single o_frame_err pulse

`timescale 1ns/1ps

module hex_word_decode (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  accel_pkg::hex_frame_t  i_frame,
   output accel_pkg::accel_val_t  o_value,
   output logic                   o_value_valid,
   output logic                   o_frame_err
);

   import accel_pkg::*;

   // {ok, nibble} for one character
   function automatic logic [4:0] hex_nibble(input ascii_char_t c);
      logic [7:0] offs;
      if (c >= ASCII_0 && c <= ASCII_9) begin
         offs = c - ASCII_0;
         return {1'b1, offs[3:0]};
      end else if (c >= ASCII_A_UP && c <= ASCII_F_UP) begin
         offs = c - ASCII_A_UP + 8'd10;
         return {1'b1, offs[3:0]};
      end else if (c >= ASCII_A_LO && c <= ASCII_F_LO) begin
         offs = c - ASCII_A_LO + 8'd10;
         return {1'b1, offs[3:0]};
      end
      return 5'b0_0000;
   endfunction

   accel_val_t dec_val;
   logic       all_ok;
   logic [4:0] nib_res;

   // char i lands in nibble i, top char is most significant
   always_comb begin
      all_ok  = 1'b1;
      dec_val = '0;
      nib_res = '0;
      for (int i = 0; i < FRAME_CHARS; i++) begin
         nib_res = hex_nibble(i_frame.chars[i]);
         all_ok  = all_ok & nib_res[4];
         dec_val[4*i +: 4] = nib_res[3:0];
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_value       <= '0;
         o_value_valid <= 1'b0;
         o_frame_err   <= 1'b0;
      end else begin
         o_value_valid <= 1'b0;
         o_frame_err   <= 1'b0;
         if (i_frame.valid) begin
            if (i_frame.len_ok && all_ok) begin
               o_value       <= dec_val;
               o_value_valid <= 1'b1;
            end else begin
               o_frame_err <= 1'b1;
            end
         end
      end
   end

endmodule

// ==== logic/ble_accel_rx.sv ====
// BLE accelerometer receive chain, serial line in, 32-bit value out
// CR byte to result pulse is 2 clocks
// CLKS_PER_TICK sets the baud rate, clk / (16 * baud)

`timescale 1ns/1ps

module ble_accel_rx #(
   parameter logic [uart_pkg::DIV_W-1:0] CLKS_PER_TICK = 11'd54
) (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  logic                   i_rx,
   output accel_pkg::accel_val_t  o_value,
   output logic                   o_value_valid,
   output logic                   o_frame_err
);

   import uart_pkg::*;
   import accel_pkg::*;

   logic       tick;
   uart_byte_t rx_byte;
   hex_frame_t frame;

   // ***************************************
   // serial front end
   // ***************************************

   baud_tick_gen #(
      .CLKS_PER_TICK (CLKS_PER_TICK)
   ) u_baud (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .o_tick  (tick)
   );

   uart_byte_rx u_rx (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_tick  (tick),
      .i_rx    (i_rx),
      .o_byte  (rx_byte)
   );

   // ***************************************
   // frame assembly and decode
   // ***************************************

   hex_frame_collect u_collect (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_byte  (rx_byte),
      .o_frame (frame)
   );

   hex_word_decode u_decode (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_frame       (frame),
      .o_value       (o_value),
      .o_value_valid (o_value_valid),
      .o_frame_err   (o_frame_err)
   );

endmodule

// ==== sim/tb_ble_accel_rx.sv ====
// testbench for the BLE accelerometer receive chain
// runs the DUT at 2 clocks per tick, so one serial bit is 32 clocks
// frames are sent one at a time and each result is awaited

`timescale 1ns/1ps

module tb_ble_accel_rx;

   import accel_pkg::*;

   localparam int CLK_NS       = 4;
   localparam int BIT_CLKS     = 16 * 2;
   localparam int CHAR_CLKS    = 10 * BIT_CLKS;
   localparam int RESULT_LIMIT = 20 * CHAR_CLKS;
   localparam int NUM_FRAMES   = 37;
   localparam int WATCHDOG_NS  = NUM_FRAMES * 12 * 10 * 32 * CLK_NS * 2;

   // just outside the digit and letter ranges
   localparam ascii_char_t NON_HEX [3] = '{8'h3A, 8'h40, 8'h67};

   typedef struct packed {
      logic       err;
      accel_val_t value;
   } exp_result_t;

   logic       clk;
   logic       i_rst_n;
   logic       i_rx;
   accel_val_t o_value;
   logic       o_value_valid;
   logic       o_frame_err;

   int          errors = 0;
   int          results = 0;
   logic [15:0] lfsr_state = 16'd55353;
   ascii_char_t sent_q[$];
   exp_result_t exp_q[$];
   accel_val_t  last_value = '0;

   ble_accel_rx #(
      .CLKS_PER_TICK (11'd2)
   ) i_dut (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_rx          (i_rx),
      .o_value       (o_value),
      .o_value_valid (o_value_valid),
      .o_frame_err   (o_frame_err)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   // ****************************************
   // random source and reference model
   // ****************************************

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic get_rand(input int nbits, output logic [31:0] r);
      r = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
   endtask

   function automatic ascii_char_t hex_char(input logic [3:0] n, input logic upper);
      if (n < 4'd10) begin
         return 8'h30 + {4'h0, n};
      end
      // 'A' is 0x37 + 10, 'a' is 0x57 + 10
      return upper ? (8'h37 + {4'h0, n}) : (8'h57 + {4'h0, n});
   endfunction

   // {ok, digit}, letters folded to lower case first
   function automatic logic [4:0] char_value(input ascii_char_t c);
      ascii_char_t folded;
      folded = c | 8'h20;
      if (c >= 8'h30 && c <= 8'h39) begin
         return {1'b1, 4'(c - 8'h30)};
      end else if (folded >= 8'h61 && folded <= 8'h66) begin
         return {1'b1, 4'(folded - 8'h57)};
      end
      return 5'h00;
   endfunction

   // good frame is exactly eight hex digits, first one on top
   function automatic exp_result_t expect_frame(input ascii_char_t chars[$],
                                                input accel_val_t prev);
      exp_result_t res;
      logic [4:0]  nib;
      res.err   = (chars.size() != FRAME_CHARS);
      res.value = '0;
      if (!res.err) begin
         for (int i = 0; i < FRAME_CHARS; i++) begin
            nib       = char_value(chars[i]);
            res.err   = res.err | !nib[4];
            res.value = {res.value[27:0], nib[3:0]};
         end
      end
      // a bad frame leaves the output alone
      if (res.err) begin
         res.value = prev;
      end
      return res;
   endfunction

   task automatic check(input string name, input logic [31:0] want, input logic [31:0] got);
      if (want !== got) begin
         $display("Error %s expected %h got %h", name, want, got);
         errors++;
      end
   endtask

   // ****************************************
   // serial stimulus
   // ****************************************

   task automatic send_bit(input logic b);
      @(posedge clk);
      i_rx <= b;
      repeat (BIT_CLKS - 1) @(posedge clk);
   endtask

   task automatic wait_results();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < RESULT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (exp_q.size() != 0) begin
         $display("no result pulse within 20 character times after a carriage return");
         errors++;
         exp_q.delete();
      end
   endtask

   // expected result is queued before the CR goes out, the pulse beats the task end
   task automatic send_char(input ascii_char_t c, input logic bad_stop);
      exp_result_t res;
      if (!bad_stop && c == ASCII_CR) begin
         res = expect_frame(sent_q, last_value);
         last_value = res.value;
         exp_q.push_back(res);
         sent_q.delete();
      end else if (!bad_stop) begin
         sent_q.push_back(c);
      end
      send_bit(1'b0);
      for (int i = 0; i < 8; i++) begin
         send_bit(c[i]);
      end
      send_bit(!bad_stop);
      // receiver needs the line high again before the next start
      if (bad_stop) begin
         send_bit(1'b1);
      end
      if (!bad_stop && c == ASCII_CR) begin
         wait_results();
      end
   endtask

   // one case bit per character, bit 7 for the first one
   task automatic send_value(input accel_val_t v, input logic [7:0] upper);
      for (int i = 7; i >= 0; i--) begin
         send_char(hex_char(v[4*i +: 4], upper[i]), 1'b0);
      end
      send_char(ASCII_CR, 1'b0);
   endtask

   task automatic send_random_chars(input int n);
      logic [31:0] r;
      for (int i = 0; i < n; i++) begin
         get_rand(4, r);
         send_char(hex_char(r[3:0], 1'b1), 1'b0);
      end
   endtask

   // ****************************************
   // result compare
   // ****************************************

   initial begin : compare
      exp_result_t want;
      forever begin
         @(negedge clk);
         if (o_value_valid || o_frame_err) begin
            if (exp_q.size() == 0) begin
               $display("result pulse seen while no frame was pending");
               errors++;
            end else begin
               want = exp_q.pop_front();
               results++;
               check("o_frame_err", 32'(want.err), 32'(o_frame_err));
               check("o_value_valid", 32'(!want.err), 32'(o_value_valid));
               check("o_value", want.value, o_value);
            end
         end
      end
   end

   initial begin : stimulus
      logic [31:0] r;
      accel_val_t  v;
      ascii_char_t bad;
      int          pos;
      i_rst_n = 1'b0;
      i_rx    = 1'b1;
      repeat (2) @(posedge clk);
      i_rst_n <= 1'b1;

      // quiet line after reset
      repeat (200) @(posedge clk);
      @(negedge clk);
      check("o_value", 32'h0, o_value);

      // upper case values
      for (int k = 0; k < 20; k++) begin
         get_rand(32, v);
         send_value(v, 8'hFF);
      end

      // lower case, then mixed case
      for (int k = 0; k < 8; k++) begin
         get_rand(32, v);
         get_rand(8, r);
         send_value(v, (k < 4) ? 8'h00 : r[7:0]);
      end

      // one non-hex character somewhere in the frame
      for (int k = 0; k < 3; k++) begin
         get_rand(32, v);
         get_rand(3, r);
         pos = int'(r[2:0]);
         for (int j = 0; j < FRAME_CHARS; j++) begin
            if (j == pos) begin
               send_char(NON_HEX[k], 1'b0);
            end else begin
               send_char(hex_char(v[4*(7-j) +: 4], 1'b1), 1'b0);
            end
         end
         send_char(ASCII_CR, 1'b0);
      end

      // short, long and empty frames
      send_random_chars(7);
      send_char(ASCII_CR, 1'b0);
      send_random_chars(9);
      send_char(ASCII_CR, 1'b0);
      send_char(ASCII_CR, 1'b0);

      // bad stop character slipped in, first one is a CR that must not end the frame
      for (int k = 0; k < 3; k++) begin
         get_rand(32, v);
         get_rand(4, r);
         pos = int'(r % 32'd9);
         get_rand(8, r);
         bad = (k == 0) ? ASCII_CR : r[7:0];
         for (int j = 0; j <= FRAME_CHARS; j++) begin
            if (j == pos) begin
               send_char(bad, 1'b1);
            end
            if (j < FRAME_CHARS) begin
               send_char(hex_char(v[4*(7-j) +: 4], 1'b1), 1'b0);
            end
         end
         send_char(ASCII_CR, 1'b0);
      end

      repeat (100) @(posedge clk);
      $display("%0d results checked, %0d errors", results, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

// ==== filelist.f ====
logic/uart_pkg.sv
logic/accel_pkg.sv
logic/baud_tick_gen.sv
logic/uart_byte_rx.sv
logic/hex_frame_collect.sv
logic/hex_word_decode.sv
logic/ble_accel_rx.sv
sim/tb_ble_accel_rx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the ble_accel_rx testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing \
   --top-module tb_ble_accel_rx \
   -f filelist.f \
   -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -qF "*** FAILED ***" sim.log; then
   echo "simulation reported failure"
   exit 1
fi

echo "simulation finished without failure"
